// File: hw/probe_pkg.sv
package probe_pkg;

    // ----------------------------------------
    // Widths and vector types
    // ----------------------------------------

    localparam int BRIGHTNESS_WIDTH = 8;

    typedef logic [1:0] mode_t;           // Logic family select.
    typedef logic [3:0] dac_code_t;       // R2R DAC code.
    typedef logic [BRIGHTNESS_WIDTH-1:0] brightness_t;

    // ----------------------------------------
    // Threshold codes for the high comparator
    // ----------------------------------------

    localparam dac_code_t DAC_CODE_1V8 = 4'd7;    // About 1.4 V.
    localparam dac_code_t DAC_CODE_2V5 = 4'd10;   // About 2.0 V.
    localparam dac_code_t DAC_CODE_3V3 = 4'd12;   // About 2.4 V, also for 5 V.

    // 50 Hz frame at a 50 MHz clock.
    localparam int FRAME_WIDTH_DEFAULT = 20;

    localparam brightness_t BRIGHTNESS_FULL = 8'd255;

    // Clear sequencer of the pulse catcher.
    typedef enum logic [1:0] {
        catch_idle,
        catch_clear,
        catch_settle
    } catch_state_t;

endpackage

// File: hw/comparator_front.sv
module comparator_front (
    input  logic                 clk,
    input  logic                 pulse_reset,
    input  logic                 comp_data_hi,
    input  logic                 comp_data_lo,
    input  probe_pkg::mode_t     mode,
    output probe_pkg::dac_code_t dac_value,
    output logic                 hi_sync,
    output logic                 lo_sync
);

    logic                 hi_meta;
    logic                 lo_meta;
    probe_pkg::dac_code_t dac_next;

    // Both comparators are asynchronous to clk.
    always_ff @(posedge clk or negedge pulse_reset) begin
        if (!pulse_reset) begin
            hi_meta <= 1'b0;
            hi_sync <= 1'b0;
            lo_meta <= 1'b0;
            lo_sync <= 1'b0;
        end else begin
            hi_meta <= comp_data_hi;
            hi_sync <= hi_meta;
            lo_meta <= comp_data_lo;
            lo_sync <= lo_meta;
        end
    end

    always_comb begin
        case (mode)
            2'd0:    dac_next = probe_pkg::DAC_CODE_1V8;
            2'd1:    dac_next = probe_pkg::DAC_CODE_2V5;
            default: dac_next = probe_pkg::DAC_CODE_3V3;   // 3.3 V and 5 V share a threshold.
        endcase
    end

    always_ff @(posedge clk or negedge pulse_reset) begin
        if (!pulse_reset) begin
            dac_value <= probe_pkg::DAC_CODE_3V3;   // Highest family until mode is seen.
        end else begin
            dac_value <= dac_next;
        end
    end

endmodule

// File: hw/frame_timer.sv
module frame_timer #(
    parameter int FRAME_WIDTH = probe_pkg::FRAME_WIDTH_DEFAULT
) (
    input  logic clk,
    input  logic pulse_reset,
    output logic frame_start,
    output logic dim_tick
);

    logic [FRAME_WIDTH-1:0] count;
    logic                   tick_window;
    logic                   tick_window_d;

    always_ff @(posedge clk or negedge pulse_reset) begin
        if (!pulse_reset) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;   // Wraps every 2^W cycles.
        end
    end

    assign frame_start = (count == '0);

    // The tick field sits just below the top 8 bits, so it repeats 256 times
    // per frame. For widths above 16 it stays at 1 for several cycles.
    assign tick_window = (count[FRAME_WIDTH-9 -: 8] == 8'd1);

    always_ff @(posedge clk or negedge pulse_reset) begin
        if (!pulse_reset) begin
            tick_window_d <= 1'b0;
        end else begin
            tick_window_d <= tick_window;
        end
    end

    // First cycle of each window only.
    assign dim_tick = tick_window & ~tick_window_d;

endmodule

// File: hw/level_accumulator.sv
module level_accumulator #(
    parameter int FRAME_WIDTH = probe_pkg::FRAME_WIDTH_DEFAULT
) (
    input  logic                   clk,
    input  logic                   pulse_reset,
    input  logic                   frame_start,
    input  logic                   hi_sync,
    input  logic                   lo_sync,
    output probe_pkg::brightness_t one_level,
    output probe_pkg::brightness_t zero_level,
    output probe_pkg::brightness_t floating_level,
    output logic                   level_load
);

    localparam int TOP = FRAME_WIDTH - 1;

    logic [FRAME_WIDTH-1:0] one_count;
    logic [FRAME_WIDTH-1:0] zero_count;
    logic [FRAME_WIDTH-1:0] floating_count;
    logic                   count_one;
    logic                   count_zero;
    logic                   count_floating;

    // A level that is neither high nor low counts as floating.
    assign count_one      = hi_sync;
    assign count_zero     = lo_sync;
    assign count_floating = ~hi_sync & ~lo_sync;

    // ----------------------------------------
    // Occupancy counters
    // ----------------------------------------

    // The frame_start cycle is never counted, so a counter tops out at 2^W-1
    // and its upper byte cannot wrap.
    always_ff @(posedge clk or negedge pulse_reset) begin
        if (!pulse_reset) begin
            one_count      <= '0;
            zero_count     <= '0;
            floating_count <= '0;
        end else if (frame_start) begin
            one_count      <= '0;
            zero_count     <= '0;
            floating_count <= '0;
        end else begin
            if (count_one) begin
                one_count <= one_count + 1'b1;
            end
            if (count_zero) begin
                zero_count <= zero_count + 1'b1;
            end
            if (count_floating) begin
                floating_count <= floating_count + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Frame results
    // ----------------------------------------

    always_ff @(posedge clk or negedge pulse_reset) begin
        if (!pulse_reset) begin
            one_level      <= '0;
            zero_level     <= '0;
            floating_level <= '0;
        end else if (frame_start) begin
            // Share of the frame, scaled to 0..255.
            one_level      <= one_count[TOP -: probe_pkg::BRIGHTNESS_WIDTH];
            zero_level     <= zero_count[TOP -: probe_pkg::BRIGHTNESS_WIDTH];
            floating_level <= floating_count[TOP -: probe_pkg::BRIGHTNESS_WIDTH];
        end
    end

    always_ff @(posedge clk or negedge pulse_reset) begin
        if (!pulse_reset) begin
            level_load <= 1'b0;
        end else begin
            level_load <= frame_start;   // New levels are valid now.
        end
    end

endmodule

// File: hw/pulse_catcher.sv
module pulse_catcher (
    input  logic                   clk,
    input  logic                   pulse_reset,
    input  logic                   comp_data_hi,
    input  logic                   frame_start,
    input  logic                   level_load,
    output probe_pkg::brightness_t pulse_level
);

    probe_pkg::catch_state_t state;
    logic                    catch_flag;
    logic                    catch_clr;
    logic                    catch_rst_n;
    logic                    flag_meta;
    logic                    flag_sync;

    // Flag is cleared by system reset or by the sequencer.
    assign catch_rst_n = pulse_reset & ~catch_clr;

    // Any rising edge sets the flag, however short the pulse.
    always_ff @(posedge comp_data_hi or negedge catch_rst_n) begin
        if (!catch_rst_n) begin
            catch_flag <= 1'b0;
        end else begin
            catch_flag <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge pulse_reset) begin
        if (!pulse_reset) begin
            flag_meta <= 1'b0;
            flag_sync <= 1'b0;
        end else begin
            flag_meta <= catch_flag;
            flag_sync <= flag_meta;
        end
    end

    // ----------------------------------------
    // Clear sequencer
    // ----------------------------------------

    always_ff @(posedge clk or negedge pulse_reset) begin
        if (!pulse_reset) begin
            state     <= probe_pkg::catch_idle;
            catch_clr <= 1'b0;
        end else begin
            case (state)
                probe_pkg::catch_idle: begin
                    if (level_load) begin   // Flag was sampled one cycle ago.
                        state     <= probe_pkg::catch_clear;
                        catch_clr <= 1'b1;
                    end
                end
                probe_pkg::catch_clear: begin
                    state     <= probe_pkg::catch_settle;
                    catch_clr <= 1'b0;
                end
                probe_pkg::catch_settle: state <= probe_pkg::catch_idle;   // Recovery time.
                default: begin
                    state     <= probe_pkg::catch_idle;
                    catch_clr <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge pulse_reset) begin
        if (!pulse_reset) begin
            pulse_level <= '0;
        end else if (frame_start) begin
            pulse_level <= flag_sync ? probe_pkg::BRIGHTNESS_FULL : '0;
        end
    end

endmodule

// File: hw/led_fader.sv
module led_fader (
    input  logic                   clk,
    input  logic                   pulse_reset,
    input  logic                   level_load,
    input  logic                   dim_tick,
    input  probe_pkg::brightness_t level,
    output logic                   led
);

    probe_pkg::brightness_t brightness;
    logic                   lit;

    assign lit = (brightness != '0);

    // ----------------------------------------
    // Brightness register
    // ----------------------------------------

    // With a 16-bit frame the first tick lands on the load cycle.
    // The load wins and the tick still samples the old value.
    always_ff @(posedge clk or negedge pulse_reset) begin
        if (!pulse_reset) begin
            brightness <= '0;
        end else if (level_load) begin
            brightness <= level;
        end else if (dim_tick && lit) begin
            brightness <= brightness - 1'b1;   // One step per tick.
        end
    end

    always_ff @(posedge clk or negedge pulse_reset) begin
        if (!pulse_reset) begin
            led <= 1'b0;
        end else if (dim_tick) begin
            led <= lit;
        end
    end

endmodule

// File: hw/logic_probe.sv
module logic_probe #(
    parameter int FRAME_WIDTH = probe_pkg::FRAME_WIDTH_DEFAULT
) (
    input  logic                 clk,
    input  logic                 pulse_reset,
    input  logic                 comp_data_hi,   // Input above DAC threshold.
    input  logic                 comp_data_lo,   // Input below 0.4 V.
    input  probe_pkg::mode_t     mode,
    output probe_pkg::dac_code_t dac_value,
    output logic                 led_one,
    output logic                 led_zero,
    output logic                 led_floating,
    output logic                 led_pulse
);

    logic                   hi_sync;
    logic                   lo_sync;
    logic                   frame_start;
    logic                   dim_tick;
    logic                   level_load;
    probe_pkg::brightness_t one_level;
    probe_pkg::brightness_t zero_level;
    probe_pkg::brightness_t floating_level;
    probe_pkg::brightness_t pulse_level;

    // ----------------------------------------
    // Front end and timing
    // ----------------------------------------

    comparator_front front_i (
        .clk          (clk),
        .pulse_reset  (pulse_reset),
        .comp_data_hi (comp_data_hi),
        .comp_data_lo (comp_data_lo),
        .mode         (mode),
        .dac_value    (dac_value),
        .hi_sync      (hi_sync),
        .lo_sync      (lo_sync)
    );

    frame_timer #(.FRAME_WIDTH(FRAME_WIDTH)) timer_i (
        .clk         (clk),
        .pulse_reset (pulse_reset),
        .frame_start (frame_start),
        .dim_tick    (dim_tick)
    );

    // ----------------------------------------
    // Measurement
    // ----------------------------------------

    level_accumulator #(.FRAME_WIDTH(FRAME_WIDTH)) accumulator_i (
        .clk            (clk),
        .pulse_reset    (pulse_reset),
        .frame_start    (frame_start),
        .hi_sync        (hi_sync),
        .lo_sync        (lo_sync),
        .one_level      (one_level),
        .zero_level     (zero_level),
        .floating_level (floating_level),
        .level_load     (level_load)
    );

    pulse_catcher catcher_i (
        .clk          (clk),
        .pulse_reset  (pulse_reset),
        .comp_data_hi (comp_data_hi),   // Raw pin, not the synchronized copy.
        .frame_start  (frame_start),
        .level_load   (level_load),
        .pulse_level  (pulse_level)
    );

    // ----------------------------------------
    // LED channels
    // ----------------------------------------

    led_fader fader_one (
        .clk (clk), .pulse_reset (pulse_reset), .level_load (level_load),
        .dim_tick (dim_tick), .level (one_level), .led (led_one)
    );

    led_fader fader_zero (
        .clk (clk), .pulse_reset (pulse_reset), .level_load (level_load),
        .dim_tick (dim_tick), .level (zero_level), .led (led_zero)
    );

    led_fader fader_floating (
        .clk (clk), .pulse_reset (pulse_reset), .level_load (level_load),
        .dim_tick (dim_tick), .level (floating_level), .led (led_floating)
    );

    led_fader fader_pulse (
        .clk (clk), .pulse_reset (pulse_reset), .level_load (level_load),
        .dim_tick (dim_tick), .level (pulse_level), .led (led_pulse)
    );

endmodule

// File: dv/logic_probe_tb.sv
module logic_probe_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TB_FRAME_WIDTH = 16;
    localparam int FRAME_CYCLES   = 1 << TB_FRAME_WIDTH;
    localparam int TICK_CYCLES    = FRAME_CYCLES / 256;   // One dim tick per 256 cycles.
    // The sequence ends in frame 8, so 12 frames leaves some margin.
    localparam int TIMEOUT_CYCLES = 12 * FRAME_CYCLES;
    localparam logic [15:0] LAST_COUNT = 16'hFFFF;

    logic                 clk;
    logic                 pulse_reset;
    logic                 comp_data_hi;
    logic                 comp_data_lo;
    probe_pkg::mode_t     mode;
    probe_pkg::dac_code_t dac_value;
    logic                 led_one;
    logic                 led_zero;
    logic                 led_floating;
    logic                 led_pulse;

    logic [15:0]          tb_count;
    int                   frame_idx;
    probe_pkg::dac_code_t exp_dac;
    logic [3:0]           leds;
    logic [3:0]           leds_prev;
    logic                 checks_on;
    integer               seed = 32'ha44;
    int                   cycles = 0;
    int                   errors;
    int                   test_errors;
    int                   tests_run;
    int                   tests_failed;
    int                   duty_cycles;
    int                   glitch_at;
    int                   i;

    // LED-on dim ticks seen in each frame.
    int one_ticks      [0:15];
    int zero_ticks     [0:15];
    int floating_ticks [0:15];
    int pulse_ticks    [0:15];

    logic_probe #(.FRAME_WIDTH(TB_FRAME_WIDTH)) logic_probe_i (
        .clk          (clk),
        .pulse_reset  (pulse_reset),
        .comp_data_hi (comp_data_hi),
        .comp_data_lo (comp_data_lo),
        .mode         (mode),
        .dac_value    (dac_value),
        .led_one      (led_one),
        .led_zero     (led_zero),
        .led_floating (led_floating),
        .led_pulse    (led_pulse)
    );

    assign leds = {led_one, led_zero, led_floating, led_pulse};

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------
    // Reference timing
    // ----------------------------------------

    // Frame position counted from reset release.
    always @(posedge clk or negedge pulse_reset) begin
        if (!pulse_reset) begin
            tb_count  <= '0;
            frame_idx <= 0;
        end else begin
            tb_count <= tb_count + 1'b1;
            if (tb_count == LAST_COUNT) begin
                frame_idx <= frame_idx + 1;
            end
        end
    end

    always @(posedge clk or negedge pulse_reset) begin
        if (!pulse_reset) begin
            exp_dac <= 4'd12;   // 3.3 V family out of reset.
        end else begin
            exp_dac <= dac_code_for(mode);
        end
    end

    function automatic probe_pkg::dac_code_t dac_code_for(input int m);
        case (m)
            0:       return 4'd7;
            1:       return 4'd10;
            default: return 4'd12;
        endcase
    endfunction

    // Cycles counted in a frame, scaled to a brightness.
    function automatic int share_ticks(input int counted);
        return counted / TICK_CYCLES;
    endfunction

    // ----------------------------------------
    // Output monitor
    // ----------------------------------------

    // LEDs update on the edge after a dim tick, so they settle at count 2 mod 256.
    always @(negedge clk) begin
        if (checks_on) begin
            assert (dac_value == exp_dac) else begin
                $display("FAILED dac_follow: expected %0d, got %0d", exp_dac, dac_value);
                errors++;
                test_errors++;
            end
            if ((tb_count % TICK_CYCLES) != 2) begin
                assert (leds == leds_prev) else begin
                    $display("An LED changed outside a dimming tick at count %0d", tb_count);
                    errors++;
                    test_errors++;
                end
            end else if (tb_count > TICK_CYCLES) begin
                if (led_one) one_ticks[frame_idx] = one_ticks[frame_idx] + 1;
                if (led_zero) zero_ticks[frame_idx] = zero_ticks[frame_idx] + 1;
                if (led_floating) floating_ticks[frame_idx] = floating_ticks[frame_idx] + 1;
                if (led_pulse) pulse_ticks[frame_idx] = pulse_ticks[frame_idx] + 1;
            end
        end
        leds_prev = leds;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Helper tasks
    // ----------------------------------------

    task automatic check_value(input string name, input int actual, input int expected,
                               input int tol);
        int diff;
        diff = actual - expected;
        if (diff < 0) diff = -diff;
        assert (diff <= tol) else begin
            $display("FAILED %s: expected %0d, got %0d", name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS %s", name);
        end else begin
            $display("FAIL %s (%0d errors)", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // Returns 1 ns after the edge that brings the frame position to value.
    task automatic wait_count(input logic [15:0] value);
        @(posedge clk);
        #1;
        while (tb_count != value) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drive_levels(input logic hi, input logic lo);
        comp_data_hi = hi;
        comp_data_lo = lo;
    endtask

    task automatic send_glitch();
        comp_data_hi = 1'b1;   // Ends well before the next clk edge.
        #1;
        comp_data_hi = 1'b0;
    endtask

    task automatic reset_dut();
        pulse_reset = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        pulse_reset = 1'b1;
        checks_on   = 1'b1;
    endtask

    task automatic run_dac_test();
        int order [4];
        int pick;
        int tmp;
        int k;
        check_value("reset_and_dac", leds, 0, 0);
        check_value("reset_and_dac", dac_value, 12, 0);
        for (k = 0; k < 4; k++) begin
            order[k] = k;
        end
        for (k = 3; k > 0; k--) begin
            pick         = {$random(seed)} % (k + 1);
            tmp          = order[k];
            order[k]     = order[pick];
            order[pick]  = tmp;
        end
        for (k = 0; k < 4; k++) begin
            mode = order[k];
            @(posedge clk);
            #1;
            check_value("reset_and_dac", dac_value, dac_code_for(order[k]), 0);
        end
        finish_test("reset_and_dac");
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    // Frame n carries the stimulus, frame n+1 shows it on the LEDs.
    initial begin
        for (i = 0; i < 16; i++) begin
            one_ticks[i]      = 0;
            zero_ticks[i]     = 0;
            floating_ticks[i] = 0;
            pulse_ticks[i]    = 0;
        end
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        checks_on    = 1'b0;
        leds_prev    = '0;
        comp_data_hi = 1'b0;
        comp_data_lo = 1'b0;
        mode         = '0;
        reset_dut();
        run_dac_test();

        wait_count(LAST_COUNT);
        drive_levels(1'b1, 1'b0);   // Frame 1 high.
        wait_count(LAST_COUNT);
        drive_levels(1'b0, 1'b1);   // Frame 2 low.
        wait_count(LAST_COUNT);
        drive_levels(1'b0, 1'b0);   // Frame 3 floating.
        check_value("steady_high/led_one", one_ticks[2], share_ticks(FRAME_CYCLES - 1), 0);
        check_value("steady_high/led_zero", zero_ticks[2], 0, 0);
        check_value("steady_high/led_floating", floating_ticks[2], 0, 0);
        finish_test("steady_high");

        duty_cycles = 512 + ({$random(seed)} % 64512);
        wait_count(LAST_COUNT);
        drive_levels(1'b1, 1'b0);   // Frame 4 high for duty_cycles.
        check_value("steady_low/led_zero", zero_ticks[3], share_ticks(FRAME_CYCLES - 1), 0);
        check_value("steady_low/led_one", one_ticks[3], 0, 0);
        check_value("steady_low/led_floating", floating_ticks[3], 0, 0);
        wait_count(duty_cycles - 1);
        drive_levels(1'b0, 1'b0);
        wait_count(LAST_COUNT);
        check_value("floating/led_floating", floating_ticks[4],
                    share_ticks(FRAME_CYCLES - 1), 0);
        check_value("floating/led_one", one_ticks[4], 0, 0);
        check_value("floating/led_zero", zero_ticks[4], 0, 0);
        finish_test("steady_low_floating");

        glitch_at = 1000 + ({$random(seed)} % 60000);
        wait_count(glitch_at);
        send_glitch();   // Frame 5, invisible to the clk domain.
        wait_count(LAST_COUNT);
        check_value("duty_share/led_one", one_ticks[5], share_ticks(duty_cycles), 2);
        check_value("duty_share/led_floating", floating_ticks[5],
                    share_ticks(FRAME_CYCLES - 1 - duty_cycles), 2);
        finish_test("duty_share");

        wait_count(LAST_COUNT);
        wait_count(LAST_COUNT);
        check_value("pulse_capture/lit", pulse_ticks[6], 255, 0);
        check_value("pulse_capture/dark", pulse_ticks[7], 0, 0);
        finish_test("pulse_capture");

        $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sim.f
hw/probe_pkg.sv
hw/comparator_front.sv
hw/frame_timer.sv
hw/level_accumulator.sv
hw/pulse_catcher.sv
hw/led_fader.sv
hw/logic_probe.sv
dv/logic_probe_tb.sv
